/* cart_geometry.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sms_loader_settings.svh"

module cart_geometry (
	input  wire                           clk_sys,
	input  wire                           arst_n,
	input  wire sms_loader_pkg::dl_beat_t dl,
	input  wire                           cart_dl,
	input  wire                           cart_start,
	input  wire                           cart_end,
	input  wire [`SMS_ROM_AW-1:0]         rom_raddr,
	output sms_loader_pkg::cart_geom_t    geom,
	output logic [`SMS_ROM_AW-1:0]        rom_addr
);

	localparam logic [`SMS_ADDR_W-1:0] hdr_addr = `SMS_HDR_BYTES;
	localparam logic [`SMS_ROM_AW-1:0] hdr_ofs  = `SMS_HDR_BYTES;
	localparam int                     hdr_bit  = $clog2(`SMS_HDR_BYTES);

	logic [`SMS_ROM_AW-1:0] mask, mask512;
	logic                   has_hdr, gg;
	logic                   cart_wr;
	logic [`SMS_ROM_AW-1:0] waddr;

	assign cart_wr = dl.wr & cart_dl;
	assign waddr   = dl.addr[`SMS_ROM_AW-1:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mask    <= '0;
			mask512 <= '0;
			has_hdr <= 1'b0;
			gg      <= 1'b0;
		end else begin
			if (cart_start) begin
				has_hdr <= 1'b0;
				gg      <= 1'b0;
			end
			if (cart_wr) begin
				// OR of all addresses gives size minus one
				mask    <= (dl.addr == '0) ? '0 : (mask | waddr);
				mask512 <= (dl.addr == hdr_addr) ? '0 : (mask512 | (waddr - hdr_ofs));
				gg      <= (dl.index[4:0] == 5'd2);
			end
			if (cart_end)
				has_hdr <= dl.addr[hdr_bit]; // Odd 512 block left over
		end
	end

	// Console read address translation
	always_comb begin
		if (has_hdr)
			rom_addr = (rom_raddr + hdr_ofs) & mask512;
		else
			rom_addr = rom_raddr & mask;
	end

	assign geom.mask    = mask;
	assign geom.mask512 = mask512;
	assign geom.has_hdr = has_hdr;
	assign geom.gg      = gg;

endmodule

`default_nettype wire

/* cheat_code_assembler.sv */
`timescale 1ns/100ps
`default_nettype none

module cheat_code_assembler (
	input  wire                           clk_sys,
	input  wire                           arst_n,
	input  wire sms_loader_pkg::dl_beat_t dl,
	input  wire                           code_dl,
	input  wire                           code_clear,
	output sms_loader_pkg::cheat_code_t   code,
	output logic                          code_valid
);

	logic [127:0] stage;      // Record being filled
	logic [127:0] stage_next;
	logic [127:0] rec;        // Last complete record
	logic [3:0]   offset;
	logic         code_wr;
	logic         last_byte;

	assign offset    = dl.addr[3:0];
	assign code_wr   = dl.wr & code_dl;
	assign last_byte = code_wr & (offset == 4'hf);

	// Word select inverted so flags end up on top
	always_comb begin
		stage_next = code_clear ? '0 : stage;
		if (code_wr)
			stage_next[{~offset[3:2], offset[1:0], 3'b000} +: 8] = dl.data;
	end

	always_ff @(posedge clk_sys) begin
		stage <= stage_next;
		if (code_clear)
			rec <= '0;
		if (last_byte)
			rec <= stage_next;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			code_valid <= 1'b0;
		else
			code_valid <= last_byte;
	end

	assign code = rec;

endmodule

`default_nettype wire

/* loader_control.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sms_loader_settings.svh"

module loader_control (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire sms_loader_pkg::dl_beat_t dl,
	input  wire                      bk_load,
	input  wire                      bk_save,
	input  wire                      img_mounted,
	input  wire                      img_readonly,
	input  wire                      img_nonzero,
	input  wire                      sd_ack,
	output logic                     cart_dl,
	output logic                     code_dl,
	output logic                     cart_start,
	output logic                     cart_end,
	output logic                     code_clear,
	output sms_loader_pkg::sd_req_t  sd,
	output logic                     bk_busy
);
	import sms_loader_pkg::*;

	dl_kind_e  kind;
	bk_state_e state;
	logic      cart_q;
	logic      bk_ena;
	logic      load_q, save_q, ack_q;
	logic      load_req, save_req;
	logic      load_rise, save_rise, auto_load;
	logic      ack_rise, ack_fall;

	// ======================================================================
	// Download classification
	// ======================================================================
	always_comb begin
		if (!dl.active)
			kind = DL_NONE;
		else if (dl.index == `SMS_CODE_INDEX)
			kind = DL_CODE;
		else
			kind = DL_CART;
	end

	assign cart_dl    = (kind == DL_CART);
	assign code_dl    = (kind == DL_CODE);
	assign cart_start = cart_dl & ~cart_q;
	assign cart_end   = ~cart_dl & cart_q;
	assign code_clear = dl.active & dl.wr & (dl.addr == '0); // First byte of any image

	assign load_req  = bk_load & bk_ena;
	assign save_req  = bk_save & bk_ena;
	assign load_rise = load_req & ~load_q;
	assign save_rise = save_req & ~save_q;
	assign auto_load = cart_end & img_nonzero & bk_ena;
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ~sd_ack & ack_q;
	assign bk_busy   = (state != BK_IDLE);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_q <= 1'b0;
			bk_ena <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			cart_q <= cart_dl;
			load_q <= load_req;
			save_q <= save_req;
			ack_q  <= sd_ack;
			if (cart_start)
				bk_ena <= 1'b0;
			// Save image gets mounted while the cart is still loading
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
		end
	end

	// ======================================================================
	// Backup sector sequencer
	// ======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= BK_IDLE;
			sd    <= '0;
		end else begin
			if (ack_rise) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end
			case (state)
				BK_IDLE: begin
					if (load_rise | save_rise) begin
						state  <= load_rise ? BK_LOAD : BK_SAVE;
						sd.lba <= '0;
						sd.rd  <= load_rise;
						sd.wr  <= ~load_rise;
					end
					if (auto_load) begin // End of cart download
						state  <= BK_LOAD;
						sd.lba <= '0;
						sd.rd  <= 1'b1;
						sd.wr  <= 1'b0;
					end
				end
				default: begin
					if (ack_fall) begin
						if (sd.lba == `SMS_BK_SECTORS - 1) begin
							state <= BK_IDLE; // Last sector done
						end else begin
							sd.lba <= sd.lba + 1'b1;
							sd.rd  <= (state == BK_LOAD);
							sd.wr  <= (state == BK_SAVE);
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rom_writer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sms_loader_settings.svh"

module rom_writer (
	input  wire                      clk_sys,
	input  wire                      arst_n,
	input  wire sms_loader_pkg::dl_beat_t dl,
	input  wire                      cart_dl,
	input  wire                      cart_start,
	input  wire                      rom_ack,
	output sms_loader_pkg::rom_wr_t  rom_wr,
	output logic                     dl_wait
);

	logic [`SMS_ROM_AW-1:0] wr_cnt;  // Next ROM byte address
	logic [`SMS_ROM_AW-1:0] wr_addr;
	logic [7:0]             wr_data;
	logic                   req;
	logic                   cart_wr;

	assign cart_wr = dl.wr & cart_dl;

	// Request toggle and host stall
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_cnt  <= '0;
			req     <= 1'b0;
			dl_wait <= 1'b0;
		end else if (cart_start) begin
			wr_cnt <= '0;
		end else if (cart_wr) begin
			dl_wait <= 1'b1;
			req     <= ~req;
		end else if (dl_wait && (req == rom_ack)) begin
			dl_wait <= 1'b0; // Memory caught up
			wr_cnt  <= wr_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr && !cart_start) begin
			wr_addr <= wr_cnt;
			wr_data <= dl.data;
		end
	end

	assign rom_wr.addr = wr_addr;
	assign rom_wr.data = wr_data;
	assign rom_wr.req  = req;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile the loader testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_sms_loader -f sms_loader.f -o sim_sms_loader

out=$(./obj_dir/sim_sms_loader 2>&1) || true
echo "$out"

if echo "$out" | grep -qx '\*\* PASS \*\*'; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* sms_loader.f */
+incdir+.
sms_loader_pkg.sv
loader_control.sv
rom_writer.sv
cart_geometry.sv
cheat_code_assembler.sv
sms_loader_top.sv
sms_loader_props.sv
tb_sms_loader.sv

/* sms_loader_pkg.sv */
`default_nettype none
`include "sms_loader_settings.svh"

package sms_loader_pkg;

	// ======================================================================
	// Host download side
	// ======================================================================
	typedef struct packed {
		logic                      active; // Download in progress
		logic                      wr;     // Byte strobe
		logic [`SMS_ADDR_W-1:0]    addr;
		logic [7:0]                data;
		logic [`SMS_INDEX_W-1:0]   index;  // Image kind from the host menu
	} dl_beat_t;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_CART,
		DL_CODE
	} dl_kind_e;

	// ======================================================================
	// Cartridge and cheats
	// ======================================================================
	typedef struct packed {
		logic [`SMS_ROM_AW-1:0] addr;
		logic [7:0]             data;
		logic                   req;   // Toggles once per write
	} rom_wr_t;

	typedef struct packed {
		logic [`SMS_ROM_AW-1:0] mask;
		logic [`SMS_ROM_AW-1:0] mask512;  // Mask with header skipped
		logic                   has_hdr;
		logic                   gg;       // Game Gear image
	} cart_geom_t;

	// Lower offsets land in lower bytes of each word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ======================================================================
	// Backup RAM sectors
	// ======================================================================
	typedef struct packed {
		logic [`SMS_LBA_W-1:0] lba;
		logic                  rd;
		logic                  wr;
	} sd_req_t;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_LOAD,
		BK_SAVE
	} bk_state_e;

endpackage

`default_nettype wire

/* sms_loader_props.sv */
`timescale 1ns/100ps
`default_nettype none

module sms_loader_props (
	input wire                           clk_sys,
	input wire                           arst_n,
	input wire sms_loader_pkg::dl_beat_t dl,
	input wire                           dl_wait,
	input wire sms_loader_pkg::rom_wr_t  rom_wr,
	input wire                           rom_ack,
	input wire                           code_valid,
	input wire sms_loader_pkg::sd_req_t  sd,
	input wire                           sd_ack,
	input wire                           bk_busy
);

	// ======================================================================
	// Host and ROM memory handshake
	// ======================================================================
	a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		dl_wait |-> !dl.wr) else $error("Host write strobe while dl_wait is high");

	a_toggle_with_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(rom_wr.req != $past(rom_wr.req)) |-> (dl_wait && !$past(dl_wait)))
		else $error("Request toggle flipped without a new write");

	a_release_on_ack: assert property (@(posedge clk_sys) disable iff (!arst_n)
		($past(dl_wait) && !dl_wait) |-> $past(rom_wr.req == rom_ack))
		else $error("dl_wait fell before the memory acknowledged");

	// ======================================================================
	// Backup sectors and cheat records
	// ======================================================================
	a_sd_one_dir: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd.rd && sd.wr)) else $error("Sector read and write requested together");

	a_sd_busy: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(sd.rd || sd.wr) |-> bk_busy) else $error("Sector request while backup idle");

	a_ack_clears: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(sd_ack) |=> !(sd.rd || sd.wr)) else $error("Sector request held after ack");

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		code_valid |=> !code_valid) else $error("code_valid longer than one cycle");

endmodule

`default_nettype wire

/* sms_loader_settings.svh */
`ifndef SMS_LOADER_SETTINGS_SVH
`define SMS_LOADER_SETTINGS_SVH

// ======================================================================
// Download stream
// ======================================================================
`define SMS_ADDR_W      25                  // Host byte address
`define SMS_INDEX_W     8                   // Download index
`define SMS_CODE_INDEX  {`SMS_INDEX_W{1'b1}} // All ones selects cheat codes

// ======================================================================
// Cartridge memory
// ======================================================================
`define SMS_ROM_AW      22                  // ROM byte address
`define SMS_HDR_BYTES   512                 // Copier header size

// Backup RAM image, 64 sectors of 512 bytes
`define SMS_BK_SECTORS  64                  // Keep a power of two
`define SMS_LBA_W       32

`endif

/* sms_loader_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sms_loader_settings.svh"

module sms_loader_top (
	input  wire                           clk_sys,
	input  wire                           arst_n,
	// Host loader
	input  wire sms_loader_pkg::dl_beat_t dl,
	output wire                           dl_wait,
	// ROM memory
	output wire sms_loader_pkg::rom_wr_t  rom_wr,
	input  wire                           rom_ack,
	// Console reads
	input  wire [`SMS_ROM_AW-1:0]         rom_raddr,
	output wire [`SMS_ROM_AW-1:0]         rom_addr,
	output wire sms_loader_pkg::cart_geom_t geom,
	// Cheats
	output wire sms_loader_pkg::cheat_code_t code,
	output wire                           code_valid,
	// Backup RAM
	input  wire                           bk_load,
	input  wire                           bk_save,
	input  wire                           img_mounted,
	input  wire                           img_readonly,
	input  wire                           img_nonzero,
	output wire sms_loader_pkg::sd_req_t  sd,
	input  wire                           sd_ack,
	output wire                           bk_busy
);

	wire cart_dl, code_dl;
	wire cart_start, cart_end;
	wire code_clear;

	loader_control u_ctrl (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonzero  (img_nonzero),
		.sd_ack       (sd_ack),
		.cart_dl      (cart_dl),
		.code_dl      (code_dl),
		.cart_start   (cart_start),
		.cart_end     (cart_end),
		.code_clear   (code_clear),
		.sd           (sd),
		.bk_busy      (bk_busy)
	);

	rom_writer u_rom_wr (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.cart_dl    (cart_dl),
		.cart_start (cart_start),
		.rom_ack    (rom_ack),
		.rom_wr     (rom_wr),
		.dl_wait    (dl_wait)
	);

	cart_geometry u_geom (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.cart_dl    (cart_dl),
		.cart_start (cart_start),
		.cart_end   (cart_end),
		.rom_raddr  (rom_raddr),
		.geom       (geom),
		.rom_addr   (rom_addr)
	);

	cheat_code_assembler u_codes (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.code_dl    (code_dl),
		.code_clear (code_clear),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

`default_nettype wire

/* tb_sms_loader.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sms_loader_settings.svh"

module tb_sms_loader;
	import sms_loader_pkg::*;

	localparam int MAX_DLY     = 3;                          // Ack delay range 0..3
	localparam int MAX_IMG     = 2048 + `SMS_HDR_BYTES;
	localparam int N_CART      = 3;
	localparam int N_XFER      = 3;                          // Save, load, automatic load
	localparam int CYCLE_LIMIT = N_CART * MAX_IMG * (MAX_DLY + 2)
		+ N_XFER * `SMS_BK_SECTORS * (2 * MAX_DLY + 2) + 2000;

	logic                   clk_sys = 1'b0;
	logic                   arst_n;
	dl_beat_t               dl;
	logic                   dl_wait, rom_ack, code_valid;
	rom_wr_t                rom_wr;
	logic [`SMS_ROM_AW-1:0] rom_raddr, rom_addr;
	cart_geom_t             geom;
	cheat_code_t            code;
	logic                   bk_load, bk_save, img_mounted, img_readonly, img_nonzero;
	sd_req_t                sd;
	logic                   sd_ack, bk_busy;

	logic [31:0] seed = 32'hb879_b725;
	logic        exp_req;      // Model of the request toggle
	cart_geom_t  exp_geom;     // Model of the last cartridge
	int          checks = 0;
	int          errors = 0;
	int          cycles;

	sms_loader_top uut (.*);

	bind sms_loader_top sms_loader_props u_props (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.dl_wait    (dl_wait),
		.rom_wr     (rom_wr),
		.rom_ack    (rom_ack),
		.code_valid (code_valid),
		.sd         (sd),
		.sd_ack     (sd_ack),
		.bk_busy    (bk_busy)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_rom_wr(input rom_wr_t got, input rom_wr_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_geom(input cart_geom_t got, input cart_geom_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_code(input cheat_code_t got, input cheat_code_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_sd(input sd_req_t got, input sd_req_t exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_addr(input logic [`SMS_ROM_AW-1:0] got,
		input logic [`SMS_ROM_AW-1:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
		end
	endtask

	// ======================================================================
	// Stimulus and responders
	// ======================================================================
	// One cart byte with the memory acking after a random delay
	task automatic send_cart_byte(input int a, input logic [7:0] d);
		rom_wr_t exp;
		logic [31:0] r;
		int dly;
		dl.wr   = 1'b1;
		dl.addr = 25'(a);
		dl.data = d;
		@(negedge clk_sys);
		dl.wr   = 1'b0;
		exp_req = ~exp_req;
		exp.addr = `SMS_ROM_AW'(a);
		exp.data = d;
		exp.req  = exp_req;
		check_rom_wr(rom_wr, exp, "ROM write");
		check_flag(dl_wait, 1'b1, "dl_wait after strobe");
		r   = lcg_next();
		dly = int'(r[9:8]);
		repeat (dly) begin
			@(negedge clk_sys);
			check_flag(dl_wait, 1'b1, "dl_wait while request outstanding");
		end
		rom_ack = rom_wr.req;
		@(negedge clk_sys);
		check_flag(dl_wait, 1'b0, "dl_wait after ack");
	endtask

	task automatic cart_download(input logic hdr, input logic nonzero, input logic ro);
		logic [31:0] r;
		int size;
		int a;
		r    = lcg_next();
		size = (1 << (10 + int'(r[12]))) + (hdr ? `SMS_HDR_BYTES : 0);
		exp_geom    = '0;
		exp_geom.gg = r[24];
		img_mounted  = 1'b1;
		img_readonly = ro;
		img_nonzero  = nonzero;
		dl.active = 1'b1;
		dl.wr     = 1'b0;
		dl.addr   = '0;
		dl.index  = {r[31:29], r[24] ? 5'd2 : 5'd1};
		@(negedge clk_sys);
		for (a = 0; a < size; a++) begin
			r = lcg_next();
			send_cart_byte(a, r[23:16]);
			exp_geom.mask = (a == 0) ? '0 : (exp_geom.mask | `SMS_ROM_AW'(a));
			if (a == `SMS_HDR_BYTES)
				exp_geom.mask512 = '0;
			else
				exp_geom.mask512 = exp_geom.mask512 | `SMS_ROM_AW'(a - `SMS_HDR_BYTES);
		end
		dl.active = 1'b0;
		dl.addr   = 25'(size); // Host address ends one past the image
		exp_geom.has_hdr = size[9];
		@(negedge clk_sys);
		check_geom(geom, exp_geom, "geometry after download");
	endtask

	task automatic check_translation(input int count);
		logic [31:0] r;
		logic [`SMS_ROM_AW-1:0] exp;
		int i;
		for (i = 0; i < count; i++) begin
			r = lcg_next();
			rom_raddr = r[`SMS_ROM_AW-1:0];
			if (exp_geom.has_hdr)
				exp = (r[`SMS_ROM_AW-1:0] + `SMS_ROM_AW'(`SMS_HDR_BYTES)) & exp_geom.mask512;
			else
				exp = r[`SMS_ROM_AW-1:0] & exp_geom.mask;
			@(negedge clk_sys);
			check_addr(rom_addr, exp, "ROM read translation");
		end
	endtask

	task automatic pulse_backup(input logic load);
		bk_load = load;
		bk_save = ~load;
		@(negedge clk_sys);
		bk_load = 1'b0;
		bk_save = 1'b0;
	endtask

	// SD side answers every sector request with a delayed ack pulse
	task automatic sd_transfer(input logic rd);
		sd_req_t exp;
		logic [31:0] r;
		int n;
		for (n = 0; n < `SMS_BK_SECTORS; n++) begin
			exp.lba = n;
			exp.rd  = rd;
			exp.wr  = ~rd;
			check_flag(bk_busy, 1'b1, "bk_busy during transfer");
			check_sd(sd, exp, "sector request");
			r = lcg_next();
			repeat (int'(r[9:8])) @(negedge clk_sys);
			sd_ack = 1'b1;
			@(negedge clk_sys);
			exp.rd = 1'b0;
			exp.wr = 1'b0;
			check_sd(sd, exp, "request cleared by ack");
			repeat (int'(r[17:16])) @(negedge clk_sys);
			sd_ack = 1'b0;
			@(negedge clk_sys);
		end
		check_flag(bk_busy, 1'b0, "bk_busy after last sector");
	endtask

	task automatic code_download(input int records);
		cheat_code_t exp;
		logic [31:0] r;
		int a;
		dl.active = 1'b1;
		dl.index  = 8'hff;
		dl.wr     = 1'b0;
		@(negedge clk_sys);
		exp = '0;
		for (a = 0; a < records * 16; a++) begin
			r = lcg_next();
			dl.wr   = 1'b1;
			dl.addr = 25'(a);
			dl.data = r[23:16];
			case (a % 16 / 4)
				0:       exp.flags[(a % 4) * 8 +: 8]   = r[23:16];
				1:       exp.addr[(a % 4) * 8 +: 8]    = r[23:16];
				2:       exp.compare[(a % 4) * 8 +: 8] = r[23:16];
				default: exp.replace[(a % 4) * 8 +: 8] = r[23:16];
			endcase
			@(negedge clk_sys);
			check_flag(code_valid, (a % 16 == 15), "code_valid");
			check_flag(dl_wait, 1'b0, "dl_wait during code download");
			if (a % 16 == 15)
				check_code(code, exp, "cheat record");
		end
		dl.wr     = 1'b0;
		dl.active = 1'b0;
		@(negedge clk_sys);
		check_flag(code_valid, 1'b0, "code_valid after download");
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial begin
		arst_n       = 1'b0;
		dl           = '0;
		rom_ack      = 1'b0;
		rom_raddr    = '0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_nonzero  = 1'b0;
		sd_ack       = 1'b0;
		exp_req      = 1'b0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		check_flag(dl_wait, 1'b0, "dl_wait after reset");
		check_flag(code_valid, 1'b0, "code_valid after reset");
		check_flag(bk_busy, 1'b0, "bk_busy after reset");
		check_flag(rom_wr.req, 1'b0, "request toggle after reset");
		check_sd(sd, '0, "sd after reset");
		check_geom(geom, '0, "geometry after reset");

		// Writable image of size zero means no automatic load
		cart_download(1'b0, 1'b0, 1'b0);
		check_translation(8);
		pulse_backup(1'b0);
		sd_transfer(1'b0);
		pulse_backup(1'b1);
		sd_transfer(1'b1);

		cart_download(1'b1, 1'b1, 1'b0);
		sd_transfer(1'b1);      // Automatic load
		check_translation(8);

		// Read-only image leaves backup disabled
		cart_download(lcg_next() >= 32'h8000_0000, 1'b1, 1'b1);
		pulse_backup(1'b1);
		repeat (8) begin
			check_flag(sd.rd | sd.wr, 1'b0, "no request for read-only image");
			check_flag(bk_busy, 1'b0, "bk_busy for read-only image");
			@(negedge clk_sys);
		end
		check_translation(8);

		code_download(5);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
